// File: verilog/cu_pkg.sv
// Control word layout, sequencing and condition enums, datapath typedefs, entry addresses
`default_nettype none

package cu_pkg;

  // ****************************************
  // Datapath value types
  // ****************************************
  typedef logic [31:0] word_t;   // Instruction word
  typedef logic [3:0]  flags_t;  // {N, Z, C, V}
  typedef logic [15:0] cr_t;     // Microword constant
  typedef logic [7:0]  uentry_t; // Fixed microroutine address

  localparam int FLAG_N = 3;
  localparam int FLAG_Z = 2;
  localparam int FLAG_C = 1;
  localparam int FLAG_V = 0;

  // Next address select, N field
  typedef enum logic [2:0] {
    jump        = 3'b000,  // CR low bits
    decode      = 3'b001,  // Encoder entry
    goto_fetch  = 3'b010,
    incr        = 3'b011,
    cond_decode = 3'b100,  // Entry if condition holds, else fetch
    cond_jump   = 3'b101   // CR if condition holds, else +1
  } next_sel_e;

  // Microbranch condition select, S field
  typedef enum logic [2:0] {
    inst_cond   = 3'b000,  // ARM condition of IR passes
    flag_z      = 3'b001,
    flag_n      = 3'b010,
    flag_c      = 3'b011,
    flag_v      = 3'b100,
    lsm_done    = 3'b101,
    always_true = 3'b110
  } cond_sel_e;

  // ****************************************
  // 64-bit microinstruction, MSB first
  // ****************************************
  typedef struct packed {
    logic [5:0] spare;
    next_sel_e  next;
    logic       inv;
    logic       mi;
    cond_sel_e  cond;
    cr_t        cr;
    logic       fr_ld;
    logic       rf_ld;
    logic       ir_ld;
    logic       mar_ld;
    logic       mdr_ld;
    logic       rw;      // 1 read, 0 write
    logic       mov;     // Memory request
    logic [1:0] ma;
    logic [2:0] mb;
    logic [2:0] mc;
    logic [1:0] md;
    logic       me;
    logic [4:0] alu_op;
    logic       sls_en;
    logic [2:0] ms;
    logic       lsm_en;
    logic [2:0] lsm_in;
    logic [1:0] mh;
    logic       mf;
  } ctrl_word_t;

  // Microroutine entry points
  localparam uentry_t ADDR_FETCH  = 8'd0;
  localparam uentry_t ADDR_DP_REG = 8'd10;
  localparam uentry_t ADDR_DP_IMM = 8'd14;
  localparam uentry_t ADDR_STR    = 8'd16;
  localparam uentry_t ADDR_LDR    = 8'd20;
  localparam uentry_t ADDR_B      = 8'd30;
  localparam uentry_t ADDR_BL     = 8'd31;

endpackage

`default_nettype wire

// File: verilog/cond_select.sv
// ARM condition evaluation and microbranch condition multiplexer with invert
`default_nettype none

module cond_select (
  input  cu_pkg::word_t     ir,
  input  cu_pkg::flags_t    flags,
  input  logic              lsm_done,
  input  cu_pkg::cond_sel_e cond,
  input  logic              inv,
  output logic              cond_true
);

  import cu_pkg::*;

  logic n, z, c, v;
  logic arm_pass; // Condition field of IR holds
  logic sel;

  assign n = flags[FLAG_N];
  assign z = flags[FLAG_Z];
  assign c = flags[FLAG_C];
  assign v = flags[FLAG_V];

  always_comb begin
    case (ir[31:28])
      4'b0000: arm_pass = z;               // EQ
      4'b0001: arm_pass = ~z;              // NE
      4'b0010: arm_pass = c;               // CS
      4'b0011: arm_pass = ~c;              // CC
      4'b0100: arm_pass = n;               // MI
      4'b0101: arm_pass = ~n;              // PL
      4'b0110: arm_pass = v;               // VS
      4'b0111: arm_pass = ~v;              // VC
      4'b1000: arm_pass = c & ~z;          // HI
      4'b1001: arm_pass = ~c | z;          // LS
      4'b1010: arm_pass = (n == v);        // GE
      4'b1011: arm_pass = (n != v);        // LT
      4'b1100: arm_pass = ~z & (n == v);   // GT
      4'b1101: arm_pass = z | (n != v);    // LE
      4'b1110: arm_pass = 1'b1;            // AL
      default: arm_pass = 1'b0;            // NV
    endcase
  end

  always_comb begin
    case (cond)
      inst_cond:         sel = arm_pass;
      flag_z:            sel = z;
      flag_n:            sel = n;
      flag_c:            sel = c;
      flag_v:            sel = v;
      cu_pkg::lsm_done:  sel = lsm_done; // Port shadows the enum literal
      always_true:       sel = 1'b1;
      default:           sel = 1'b0;
    endcase
  end

  assign cond_true = sel ^ inv;

endmodule

`default_nettype wire

// File: verilog/inst_encoder.sv
// Instruction class decode to microroutine entry address
`default_nettype none

module inst_encoder #(
  parameter int UADDR_W = 8
) (
  input  cu_pkg::word_t      ir,
  output logic [UADDR_W-1:0] entry
);

  import cu_pkg::*;

  logic [2:0] op_class; // IR bits 27:25
  logic       l_bit;
  logic       link;
  uentry_t    target;

  assign op_class = ir[27:25];
  assign l_bit    = ir[20];
  assign link     = ir[24];

  always_comb begin
    case (op_class)
      3'b000: target = ADDR_DP_REG;
      3'b001: target = ADDR_DP_IMM;
      3'b010: begin
        // Single transfer, immediate offset
        if (l_bit) begin
          target = ADDR_LDR;
        end else begin
          target = ADDR_STR;
        end
      end
      3'b101: begin
        if (link) begin
          target = ADDR_BL;
        end else begin
          target = ADDR_B;
        end
      end
      default: target = ADDR_FETCH; // Unsupported class, refetch
    endcase
  end

  assign entry = UADDR_W'(target);

endmodule

`default_nettype wire

// File: verilog/micro_seq.sv
// Microaddress register with next-address selection and memory wait hold
`default_nettype none

module micro_seq #(
  parameter int UADDR_W = 8
) (
  input  logic               clk,
  input  logic               rst_n,
  input  cu_pkg::next_sel_e  next,
  input  cu_pkg::cr_t        cr,
  input  logic [UADDR_W-1:0] entry,
  input  logic               cond_true,
  input  logic               mov,
  input  logic               mem_ready,
  output logic [UADDR_W-1:0] uaddr
);

  import cu_pkg::*;

  logic [UADDR_W-1:0] fetch_addr;
  logic [UADDR_W-1:0] incr_addr;
  logic [UADDR_W-1:0] jump_addr;
  logic [UADDR_W-1:0] next_addr;
  logic               mem_wait;

  assign fetch_addr = UADDR_W'(ADDR_FETCH);
  assign incr_addr  = uaddr + UADDR_W'(1);
  assign jump_addr  = cr[UADDR_W-1:0]; // Upper CR bits ignored

  // Request pending and memory not ready
  assign mem_wait = mov & ~mem_ready;

  // ****************************************
  // Next address selection
  // ****************************************
  always_comb begin
    case (next)
      goto_fetch: next_addr = fetch_addr;
      decode:     next_addr = entry;
      jump:       next_addr = jump_addr;
      incr:       next_addr = incr_addr;
      cond_jump: begin
        next_addr = cond_true ? jump_addr : incr_addr;
      end
      cond_decode: begin
        // Failed condition skips the instruction
        next_addr = cond_true ? entry : fetch_addr;
      end
      default:    next_addr = fetch_addr;
    endcase
  end

  // ****************************************
  // Microaddress register
  // ****************************************
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      uaddr <= fetch_addr;
    end else if (!mem_wait) begin
      uaddr <= next_addr;
    end
  end

endmodule

`default_nettype wire

// File: verilog/control_store.sv
// Microprogram ROM for fetch, data processing, load/store and branch routines
`default_nettype none

module control_store #(
  parameter int UADDR_W = 8
) (
  input  logic [UADDR_W-1:0] uaddr,
  output cu_pkg::ctrl_word_t ctrl
);

  import cu_pkg::*;

  // Literal groups, left to right:
  //   spare _ N _ INV MI _ S _ CR _ FR RF IR MAR MDR _ RW MOV
  //   _ MA MB MC MD ME _ OP _ SLS MS LSM LSM_IN MH MF
  // MA 00 PC, 01 Rn. MB 001 const 4, 010 shifted Rm, 011 rotated imm8,
  // 100 imm12, 101 branch offset, 110 zero. MC 000 PC, 001 Rd, 010 LR
  // MD 01 MDR from memory, 10 MDR from Rd. ME selects MDR into the file
  // OP 00100 add, 10000 opcode taken from IR

  always_comb begin
    case (uaddr)
      // ****************************************
      // Fetch
      // ****************************************
      0: ctrl = 64'b000000_011_00_110_0000000000000000_00010_00_00000000000_00000_00000000000;
      1: ctrl = 64'b000000_011_00_110_0000000000000000_00001_11_00000000010_00000_00000000000;
      2: ctrl = 64'b000000_011_00_110_0000000000000000_01100_00_00001000000_00100_00000000000;
      3: ctrl = 64'b000000_100_00_000_0000000000000000_00000_00_00000000000_00000_00000000000;

      // ****************************************
      // Data processing, register operand
      // ****************************************
      10: ctrl = 64'b000000_011_00_110_0000000000000000_01000_00_01010001000_10000_10000000000;
      11: ctrl = 64'b000000_010_00_110_0000000000000000_10000_00_01010001000_10000_10000000000;

      // ****************************************
      // Data processing, immediate operand
      // ****************************************
      14: ctrl = 64'b000000_011_00_110_0000000000000000_01000_00_01011001000_10000_10010000000;
      15: ctrl = 64'b000000_010_00_110_0000000000000000_10000_00_01011001000_10000_10010000000;

      // ****************************************
      // Store word
      // ****************************************
      16: ctrl = 64'b000000_011_00_110_0000000000000000_00010_00_01100000000_00100_00000000000;
      17: ctrl = 64'b000000_011_00_110_0000000000000000_00001_00_00000000100_00000_00000000000;
      18: ctrl = 64'b000000_010_00_110_0000000000000000_00000_01_00000000000_00000_00000000000;

      // ****************************************
      // Load word
      // ****************************************
      20: ctrl = 64'b000000_011_00_110_0000000000000000_00010_00_01100000000_00100_00000000000;
      21: ctrl = 64'b000000_011_00_110_0000000000000000_00001_11_00000000010_00000_00000000000;
      22: ctrl = 64'b000000_010_00_110_0000000000000000_01000_00_00000001001_00000_00000000000;

      // ****************************************
      // Branch, branch with link
      // ****************************************
      30: ctrl = 64'b000000_010_00_110_0000000000000000_01000_00_00101000000_00100_00000000000;
      // LR gets PC, then reuse the plain branch word
      31: ctrl = 64'b000000_000_00_110_0000000000011110_01000_00_00110010000_00100_00000000000;

      // Stray address falls back to fetch
      default: ctrl = 64'b000000_010_00_110_0000000000000000_00000_00_00000000000_00000_00000000000;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/control_unit.sv
// Control unit top with encoder, condition select, sequencer and control store
`default_nettype none

module control_unit #(
  parameter int UADDR_W = 8
) (
  input  logic               clk,
  input  logic               rst_n,
  input  cu_pkg::word_t      ir,
  input  cu_pkg::flags_t     flags,
  input  logic               lsm_done,
  input  logic               mem_ready,
  output cu_pkg::ctrl_word_t ctrl,
  output logic [UADDR_W-1:0] uaddr,
  output logic               mem_valid
);

  logic [UADDR_W-1:0] entry;     // Routine entry for current IR
  logic               cond_true;

  assign mem_valid = ctrl.mov;   // Request tracks the microword

  inst_encoder #(
    .UADDR_W (UADDR_W)
  ) u_inst_encoder (
    .ir    (ir),
    .entry (entry)
  );

  cond_select u_cond_select (
    .ir        (ir),
    .flags     (flags),
    .lsm_done  (lsm_done),
    .cond      (ctrl.cond),
    .inv       (ctrl.inv),
    .cond_true (cond_true)
  );

  micro_seq #(
    .UADDR_W (UADDR_W)
  ) u_micro_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .next      (ctrl.next),
    .cr        (ctrl.cr),
    .entry     (entry),
    .cond_true (cond_true),
    .mov       (ctrl.mov),
    .mem_ready (mem_ready),
    .uaddr     (uaddr)
  );

  control_store #(
    .UADDR_W (UADDR_W)
  ) u_control_store (
    .uaddr (uaddr),
    .ctrl  (ctrl)
  );

endmodule

`default_nettype wire

// File: bench/control_unit_assert.sv
// Bound concurrent assertions for reset, memory hold, decode and sequencing rules
`default_nettype none

module control_unit_assert #(
  parameter int UADDR_W = 8
) (
  input logic               clk,
  input logic               rst_n,
  input cu_pkg::word_t      ir,
  input cu_pkg::flags_t     flags,
  input logic               mem_ready,
  input cu_pkg::ctrl_word_t ctrl,
  input logic [UADDR_W-1:0] uaddr,
  input logic               mem_valid
);

  timeunit 1ns;
  timeprecision 1ns;

  import cu_pkg::*;

  logic [UADDR_W-1:0] expected_entry;
  logic [UADDR_W-1:0] prev_expected;
  logic [UADDR_W-1:0] prev_uaddr;
  ctrl_word_t         prev_ctrl;
  logic               prev_rst_n;
  logic               mem_wait;
  int                 fail_count = 0;

  // ARM condition by pairs, odd codes invert the even one
  function automatic logic cond_holds(input logic [3:0] cc, input flags_t f);
    logic base;
    case (cc[3:1])
      3'd0: base = f[FLAG_Z];
      3'd1: base = f[FLAG_C];
      3'd2: base = f[FLAG_N];
      3'd3: base = f[FLAG_V];
      3'd4: base = f[FLAG_C] && !f[FLAG_Z];
      3'd5: base = (f[FLAG_N] == f[FLAG_V]);
      3'd6: base = !f[FLAG_Z] && (f[FLAG_N] == f[FLAG_V]);
      default: base = 1'b1;
    endcase
    if (cc == 4'hF) begin
      return 1'b0;
    end
    return base ^ cc[0];
  endfunction

  function automatic uentry_t class_entry(input word_t w);
    case (w[27:25])
      3'b000: return ADDR_DP_REG;
      3'b001: return ADDR_DP_IMM;
      3'b010: return w[20] ? ADDR_LDR : ADDR_STR;
      3'b101: return w[24] ? ADDR_BL : ADDR_B;
      default: return ADDR_FETCH;
    endcase
  endfunction

  assign expected_entry = cond_holds(ir[31:28], flags) ? UADDR_W'(class_entry(ir)) : '0;
  assign mem_wait       = mem_valid & ~mem_ready;

  always @(posedge clk) begin
    prev_expected <= expected_entry;
    prev_uaddr    <= uaddr;
    prev_ctrl     <= ctrl;
    prev_rst_n    <= rst_n;
  end

  // ****************************************
  // Reset state
  // ****************************************
  a_reset_uaddr: assert property (@(posedge clk) !rst_n && !prev_rst_n |-> uaddr == '0)
    else begin
      fail_count++;
      $error("Error reset_uaddr: expected 0, actual %0d", $sampled(uaddr));
    end

  a_reset_quiet: assert property (@(posedge clk) !rst_n && !prev_rst_n |->
      !mem_valid && !ctrl.mov && !ctrl.fr_ld && !ctrl.rf_ld && !ctrl.ir_ld && !ctrl.mdr_ld)
    else begin
      fail_count++;
      $error("Memory request or register load active while reset is held");
    end

  // ****************************************
  // Sequencing
  // ****************************************
  a_mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
      mem_wait |=> uaddr == prev_uaddr && ctrl == prev_ctrl)
    else begin
      fail_count++;
      $error("Error mem_hold: expected %0d, actual %0d", $sampled(prev_uaddr), $sampled(uaddr));
    end

  a_decode: assert property (@(posedge clk) disable iff (!rst_n)
      uaddr == 3 |=> uaddr == prev_expected)
    else begin
      fail_count++;
      $error("Error decode: expected %0d, actual %0d", $sampled(prev_expected), $sampled(uaddr));
    end

  a_incr: assert property (@(posedge clk) disable iff (!rst_n)
      ctrl.next == incr && !mem_wait |=> uaddr == UADDR_W'(prev_uaddr + 1'b1))
    else begin
      fail_count++;
      $error("Error incr: expected %0d, actual %0d",
             UADDR_W'($sampled(prev_uaddr) + 1'b1), $sampled(uaddr));
    end

  a_goto_fetch: assert property (@(posedge clk) disable iff (!rst_n)
      ctrl.next == goto_fetch && !mem_wait |=> uaddr == '0)
    else begin
      fail_count++;
      $error("Error goto_fetch: expected 0, actual %0d", $sampled(uaddr));
    end

  // Fetch order
  a_ir_ld: assert property (@(posedge clk) disable iff (!rst_n) ctrl.ir_ld |-> uaddr == 2)
    else begin
      fail_count++;
      $error("Error ir_ld: expected uaddr 2, actual %0d", $sampled(uaddr));
    end

  a_mar_ld: assert property (@(posedge clk) disable iff (!rst_n) uaddr == 0 |-> ctrl.mar_ld)
    else begin
      fail_count++;
      $error("MAR load missing at the first fetch word");
    end

endmodule

`default_nettype wire

// File: bench/control_unit_tb.sv
// Control unit testbench with random instruction stream, stuck-address check and timeout
`default_nettype none

module control_unit_tb;

  timeunit 1ns;
  timeprecision 1ns;

  import cu_pkg::*;

  localparam int UADDR_W     = 8;
  localparam int N_INSTR     = 200;
  localparam int RESET_CYC   = 8;
  localparam int CYCLE_LIMIT = 40 * N_INSTR + RESET_CYC;

  logic               clk;
  logic               rst_n;
  word_t              ir;
  flags_t             flags;
  logic               lsm_done;
  logic               mem_ready;
  ctrl_word_t         ctrl;
  logic [UADDR_W-1:0] uaddr;
  logic               mem_valid;

  integer             seed = 32'h3695874e;
  int                 instr_done = 0;
  int                 cycles = 0;
  int                 stuck_errors = 0;
  int                 assert_errors;
  logic [UADDR_W-1:0] last_uaddr;
  bit                 advance_due = 1'b0; // Previous cycle had no memory wait

  control_unit #(
    .UADDR_W (UADDR_W)
  ) dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .ir        (ir),
    .flags     (flags),
    .lsm_done  (lsm_done),
    .mem_ready (mem_ready),
    .ctrl      (ctrl),
    .uaddr     (uaddr),
    .mem_valid (mem_valid)
  );

  bind control_unit control_unit_assert #(
    .UADDR_W (UADDR_W)
  ) u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .ir        (ir),
    .flags     (flags),
    .mem_ready (mem_ready),
    .ctrl      (ctrl),
    .uaddr     (uaddr),
    .mem_valid (mem_valid)
  );

  always #50 clk = ~clk;

  // Random instruction of a chosen class, condition nibble stays random
  task automatic make_instr(output word_t instr);
    int    kind;
    word_t raw;
    kind = $random(seed) & 7;
    raw  = $random(seed);
    case (kind)
      0: raw[27:25] = 3'b000;                    // DP register
      1: raw[27:25] = 3'b001;                    // DP immediate
      2: raw[27:20] = {3'b010, raw[24:21], 1'b0}; // STR
      3: raw[27:20] = {3'b010, raw[24:21], 1'b1}; // LDR
      4: raw[27:24] = 4'b1010;                   // B
      5: raw[27:24] = 4'b1011;                   // BL
      6: raw[27:25] = {1'b1, raw[26], 1'b0};     // Unsupported 100/110
      default: raw[27:25] = {raw[27], 2'b11};    // Unsupported 011/111
    endcase
    instr = raw;
  endtask

  // ****************************************
  // Stimulus
  // ****************************************
  always @(posedge clk) begin : drive_inputs
    word_t next_ir;
    int    r;
    if (rst_n) begin
      r = $random(seed);
      mem_ready <= r[0];  // Low about half the time
      lsm_done  <= r[1];
      if (uaddr == 3 && instr_done < N_INSTR) begin
        make_instr(next_ir);
        ir         <= next_ir;
        flags      <= flags_t'($random(seed));
        instr_done <= instr_done + 1;
      end
    end
  end

  // Microaddress must move on every cycle without a memory wait
  always @(posedge clk) begin : stuck_check
    if (!rst_n) begin
      advance_due = 1'b0;
    end else begin
      if (advance_due && uaddr == last_uaddr) begin
        stuck_errors++;
        $display("Microaddress stuck at %0d with no memory wait pending", uaddr);
      end
      last_uaddr  = uaddr;
      advance_due = !(mem_valid && !mem_ready);
    end
  end

  always @(posedge clk) begin : watchdog
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, only %0d of %0d instructions finished",
               cycles, instr_done, N_INSTR);
      $display("Something failed");
      $finish;
    end
  end

  initial begin : run
    word_t first_ir;
    clk       = 1'b0;
    rst_n     = 1'b0;
    lsm_done  = 1'b0;
    mem_ready = 1'b0;
    make_instr(first_ir);
    ir    = first_ir;
    flags = flags_t'($random(seed));
    repeat (RESET_CYC) @(posedge clk);
    rst_n <= 1'b1;
    wait (instr_done == N_INSTR);
    repeat (2) @(posedge clk); // Let the last decode check complete
    assert_errors = dut.u_assert.fail_count;
    $display("Summary: %0d instructions, %0d assertion errors, %0d stuck-address errors",
             instr_done, assert_errors, stuck_errors);
    if (assert_errors == 0 && stuck_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
verilog/cu_pkg.sv
verilog/cond_select.sv
verilog/inst_encoder.sv
verilog/micro_seq.sv
verilog/control_store.sv
verilog/control_unit.sv
bench/control_unit_assert.sv
bench/control_unit_tb.sv

// File: Bender.yml
package:
  name: control_unit

sources:
  - verilog/cu_pkg.sv
  - verilog/cond_select.sv
  - verilog/inst_encoder.sv
  - verilog/micro_seq.sv
  - verilog/control_store.sv
  - verilog/control_unit.sv
  - target: test
    files:
      - bench/control_unit_assert.sv
      - bench/control_unit_tb.sv
